// ==== design/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath and cache address widths
`define RV_XLEN      32
`define RV_ADDR_W    30
`define RV_REG_W     5
`define RV_NREGS     32

// start address after reset
`define RV_RESET_PC  32'h0000_0000

// addi x0, x0, 0
`define RV_NOP       32'h0000_0013

// instruction field positions
`define RV_OPC_LSB   0
`define RV_OPC_W     7
`define RV_RD_LSB    7
`define RV_F3_LSB    12
`define RV_RS1_LSB   15
`define RV_RS2_LSB   20
`define RV_F7_ALT    30

`endif

// ==== design/rv_pkg.sv ====
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_ADDR_W-1:0] addr_t;
    typedef logic [`RV_REG_W-1:0]  reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [`RV_OPC_W-1:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_t;

    // funct3 encoding, sub borrows the spare 011 slot
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_slt = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_sr  = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {hz_run, hz_load_bubble, hz_flush} hazard_state_t;

    // both cache buses carry byte 0 in the top byte
    function automatic word_t byte_swap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

`default_nettype wire

// ==== design/rv_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_fetch (
    input  logic          clk,
    input  logic          reset_r,
    input  logic          hold,
    input  logic          bubble,
    input  logic          flush,
    input  logic          redirect,
    input  rv_pkg::word_t redirect_pc,
    input  rv_pkg::word_t icache_rdata,
    output logic          icache_ren,
    output rv_pkg::addr_t icache_addr,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t if_instr,
    output rv_pkg::word_t if_pc
);
    import rv_pkg::*;

    // low for the first cycle out of reset
    logic fetch_on;

    assign icache_ren  = fetch_on;
    assign icache_addr = pc[`RV_XLEN-1:2];

    always_ff @(posedge clk) begin
        if (reset_r) begin
            fetch_on <= 1'b0;
            pc       <= `RV_RESET_PC;
            if_instr <= `RV_NOP;
        end else begin
            fetch_on <= 1'b1;
            if (!hold) begin
                // taken branch or jump resolved in execute
                if (redirect) begin
                    pc <= redirect_pc;
                end else if (fetch_on && !bubble) begin
                    pc <= pc + 32'd4;
                end
                if (flush || !fetch_on) begin
                    if_instr <= `RV_NOP;
                end else if (!bubble) begin
                    if_instr <= byte_swap(icache_rdata);
                end
            end
        end
    end

    // pc of the word sitting in IF/ID
    always_ff @(posedge clk) begin
        if (!hold && !bubble) begin
            if_pc <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_regfile (
    input  logic             clk,
    input  logic             reset_r,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t wb_rd,
    input  rv_pkg::word_t    wb_value,
    input  logic             wb_en,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:`RV_NREGS-1];

    // write-through so decode sees the value retiring this cycle
    function automatic word_t read_port(input reg_idx_t idx);
        word_t value;
        if (idx == '0) begin
            value = '0;
        end else if (wb_en && wb_rd == idx) begin
            value = wb_value;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_r) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_value;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

`default_nettype wire

// ==== design/rv_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_decode (
    input  logic             clk,
    input  logic             reset_r,
    input  logic             hold,
    input  logic             bubble,
    input  logic             flush,
    input  rv_pkg::word_t    if_instr,
    input  rv_pkg::word_t    if_pc,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t ex_rd,
    input  rv_pkg::word_t    ex_value,
    input  rv_pkg::reg_idx_t mem_rd,
    input  rv_pkg::word_t    mem_value,
    output logic             id_is_load,
    output rv_pkg::reg_idx_t id_rd,
    output rv_pkg::word_t    id_a,
    output rv_pkg::word_t    id_b,
    output rv_pkg::word_t    id_store_value,
    output rv_pkg::word_t    id_branch_pc,
    output rv_pkg::word_t    id_pc,
    output rv_pkg::alu_op_t  id_alu_op,
    output logic             id_sra,
    output logic             id_branch,
    output logic             id_bne,
    output logic             id_jal,
    output logic             id_jalr,
    output logic             id_load,
    output logic             id_store
);
    import rv_pkg::*;

    reg_idx_t   rd;
    logic [2:0] funct3;
    word_t      imm_i, imm_s, imm_b, imm_j;
    word_t      rs1_fwd, rs2_fwd;
    word_t      a_next, b_next;
    reg_idx_t   rd_next;
    alu_op_t    alu_next;
    logic       branch_next, jal_next, jalr_next, load_next, store_next;

    assign rd     = if_instr[`RV_RD_LSB +: `RV_REG_W];
    assign rs1    = if_instr[`RV_RS1_LSB +: `RV_REG_W];
    assign rs2    = if_instr[`RV_RS2_LSB +: `RV_REG_W];
    assign funct3 = if_instr[`RV_F3_LSB +: 3];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                    if_instr[11:8], 1'b0};
    assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
                    if_instr[30:21], 1'b0};

    // youngest producer wins, older ones come through the register file
    assign rs1_fwd = (ex_rd != '0 && ex_rd == rs1) ? ex_value :
                     (mem_rd != '0 && mem_rd == rs1) ? mem_value : rs1_data;
    assign rs2_fwd = (ex_rd != '0 && ex_rd == rs2) ? ex_value :
                     (mem_rd != '0 && mem_rd == rs2) ? mem_value : rs2_data;

    // a load into x0 never needs the bubble
    assign id_is_load = id_load && (id_rd != '0);

    always_comb begin
        // defaults fit op_imm, jalr and load
        a_next      = rs1_fwd;
        b_next      = imm_i;
        rd_next     = rd;
        alu_next    = alu_add;
        branch_next = 1'b0;
        jal_next    = 1'b0;
        jalr_next   = 1'b0;
        load_next   = 1'b0;
        store_next  = 1'b0;
        case (opcode_t'(if_instr[`RV_OPC_LSB +: `RV_OPC_W]))
            opc_op: begin
                b_next   = rs2_fwd;
                alu_next = (funct3 == 3'b000 && if_instr[`RV_F7_ALT]) ? alu_sub
                                                                     : alu_op_t'(funct3);
            end
            opc_op_imm: alu_next = alu_op_t'(funct3);
            opc_branch: begin
                b_next      = rs2_fwd;
                rd_next     = '0;
                branch_next = 1'b1;
            end
            opc_jal: begin
                a_next   = if_pc;
                b_next   = imm_j;
                jal_next = 1'b1;
            end
            opc_jalr:  jalr_next = 1'b1;
            opc_load:  load_next = 1'b1;
            opc_store: begin
                b_next     = imm_s;
                rd_next    = '0;
                store_next = 1'b1;
            end
            default:   rd_next = '0;
        endcase
    end

    // ID/EX control, a nop on flush or bubble
    always_ff @(posedge clk) begin
        if (reset_r || (!hold && (flush || bubble))) begin
            id_rd     <= '0;
            id_alu_op <= alu_add;
            id_sra    <= 1'b0;
            id_branch <= 1'b0;
            id_bne    <= 1'b0;
            id_jal    <= 1'b0;
            id_jalr   <= 1'b0;
            id_load   <= 1'b0;
            id_store  <= 1'b0;
        end else if (!hold) begin
            id_rd     <= rd_next;
            id_alu_op <= alu_next;
            id_sra    <= if_instr[`RV_F7_ALT];
            id_branch <= branch_next;
            id_bne    <= funct3[0];
            id_jal    <= jal_next;
            id_jalr   <= jalr_next;
            id_load   <= load_next;
            id_store  <= store_next;
        end
    end

    // ID/EX operands
    always_ff @(posedge clk) begin
        if (!hold) begin
            id_a           <= a_next;
            id_b           <= b_next;
            id_store_value <= rs2_fwd;
            id_branch_pc   <= if_pc + imm_b;
            id_pc          <= if_pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_hazard_control.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_hazard_control (
    input  logic             clk,
    input  logic             reset_r,
    input  logic             icache_stall,
    input  logic             dcache_stall,
    input  logic             id_is_load,
    input  rv_pkg::reg_idx_t id_rd,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  logic             redirect,
    output logic             hold,
    output logic             bubble,
    output logic             flush
);
    import rv_pkg::*;

    hazard_state_t state, state_next;
    logic          load_hit;

    // id_is_load already excludes rd == x0
    assign load_hit = id_is_load && (rs1 == id_rd || rs2 == id_rd);

    // either cache stalling freezes every stage
    assign hold   = icache_stall | dcache_stall;
    assign flush  = !hold && redirect;
    assign bubble = !hold && (state == hz_run) && load_hit;

    always_comb begin
        if (hold) begin
            state_next = state;
        end else if (flush) begin
            state_next = hz_flush;
        end else if (bubble) begin
            state_next = hz_load_bubble;
        end else begin
            state_next = hz_run;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_r) begin
            state <= hz_run;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_execute (
    input  logic             clk,
    input  logic             reset_r,
    input  logic             hold,
    input  rv_pkg::reg_idx_t id_rd,
    input  rv_pkg::word_t    id_a,
    input  rv_pkg::word_t    id_b,
    input  rv_pkg::word_t    id_store_value,
    input  rv_pkg::word_t    id_branch_pc,
    input  rv_pkg::word_t    id_pc,
    input  rv_pkg::alu_op_t  id_alu_op,
    input  logic             id_sra, id_branch, id_bne, id_jal, id_jalr, id_load, id_store,
    output logic             redirect,
    output rv_pkg::word_t    redirect_pc,
    output rv_pkg::reg_idx_t fwd_rd,
    output rv_pkg::word_t    fwd_value,
    output rv_pkg::reg_idx_t ex_rd,
    output rv_pkg::word_t    ex_value,
    output rv_pkg::word_t    ex_store_value,
    output rv_pkg::word_t    ex_pc,
    output logic             ex_load, ex_store, ex_link
);
    import rv_pkg::*;

    word_t alu_result;
    logic  taken;

    always_comb begin
        case (id_alu_op)
            alu_add: alu_result = id_a + id_b;
            alu_sub: alu_result = id_a - id_b;
            alu_and: alu_result = id_a & id_b;
            alu_or:  alu_result = id_a | id_b;
            alu_xor: alu_result = id_a ^ id_b;
            alu_slt: alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(id_a) < $signed(id_b)};
            alu_sll: alu_result = id_a << id_b[4:0];
            alu_sr:  alu_result = id_sra ? word_t'($signed(id_a) >>> id_b[4:0])
                                         : id_a >> id_b[4:0];
            default: alu_result = id_a + id_b;
        endcase
    end

    // static not-taken, so any taken transfer redirects
    assign taken       = id_branch && ((id_a == id_b) != id_bne);
    assign redirect    = taken | id_jal | id_jalr;
    assign redirect_pc = taken ? id_branch_pc
                               : {alu_result[`RV_XLEN-1:1], alu_result[0] & ~id_jalr};

    // load data is not here yet, the bubble covers that case
    assign fwd_rd    = id_load ? '0 : id_rd;
    assign fwd_value = alu_result;

    always_ff @(posedge clk) begin
        if (reset_r) begin
            ex_rd    <= '0;
            ex_load  <= 1'b0;
            ex_store <= 1'b0;
            ex_link  <= 1'b0;
        end else if (!hold) begin
            ex_rd    <= id_rd;
            ex_load  <= id_load;
            ex_store <= id_store;
            ex_link  <= id_jal | id_jalr;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_value       <= alu_result;
            ex_store_value <= id_store_value;
            ex_pc          <= id_pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_memory (
    input  logic             clk,
    input  logic             reset_r,
    input  logic             hold,
    input  rv_pkg::reg_idx_t ex_rd,
    input  rv_pkg::word_t    ex_value,
    input  rv_pkg::word_t    ex_store_value,
    input  rv_pkg::word_t    ex_pc,
    input  logic             ex_load, ex_store, ex_link,
    output logic             dcache_ren,
    output logic             dcache_wen,
    output rv_pkg::addr_t    dcache_addr,
    output rv_pkg::word_t    dcache_wdata,
    input  rv_pkg::word_t    dcache_rdata,
    output rv_pkg::reg_idx_t mem_rd,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    mem_value,
    output rv_pkg::word_t    wb_value,
    output logic             wb_en
);
    import rv_pkg::*;

    // data cache driven straight from EX/MEM
    assign dcache_ren   = ex_load;
    assign dcache_wen   = ex_store;
    assign dcache_addr  = ex_value[`RV_XLEN-1:2];
    assign dcache_wdata = byte_swap(ex_store_value);

    // also the older forwarding source for decode
    assign mem_rd = ex_rd;

    always_comb begin
        if (ex_link) begin
            mem_value = ex_pc + 32'd4;
        end else if (ex_load) begin
            mem_value = byte_swap(dcache_rdata);
        end else begin
            mem_value = ex_value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_r) begin
            wb_rd <= '0;
            wb_en <= 1'b0;
        end else if (!hold) begin
            wb_rd <= ex_rd;
            wb_en <= (ex_rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            wb_value <= mem_value;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_core (
    input  logic          clk,
    input  logic          reset_r,
    output logic          icache_ren,
    output rv_pkg::addr_t icache_addr,
    input  rv_pkg::word_t icache_rdata,
    input  logic          icache_stall,
    output logic          dcache_ren,
    output logic          dcache_wen,
    output rv_pkg::addr_t dcache_addr,
    output rv_pkg::word_t dcache_wdata,
    input  rv_pkg::word_t dcache_rdata,
    input  logic          dcache_stall,
    output rv_pkg::word_t pc
);
    import rv_pkg::*;

    // hazard control
    logic     hold, bubble, flush;
    logic     redirect;
    word_t    redirect_pc;

    // IF/ID and register file
    word_t    if_instr, if_pc;
    reg_idx_t rs1, rs2;
    word_t    rs1_data, rs2_data;

    // ID/EX
    logic     id_is_load;
    reg_idx_t id_rd;
    word_t    id_a, id_b, id_store_value, id_branch_pc, id_pc;
    alu_op_t  id_alu_op;
    logic     id_sra, id_branch, id_bne, id_jal, id_jalr, id_load, id_store;

    // EX/MEM and the forwarding taps
    reg_idx_t fwd_rd, ex_rd, mem_rd;
    word_t    fwd_value, ex_value, mem_value;
    word_t    ex_store_value, ex_pc;
    logic     ex_load, ex_store, ex_link;

    // MEM/WB
    reg_idx_t wb_rd;
    word_t    wb_value;
    logic     wb_en;

    rv_fetch u_fetch (.*);

    rv_regfile u_regfile (.*);

    // execute-stage result is the youngest forwarding source
    rv_decode u_decode (
        .ex_rd    (fwd_rd),
        .ex_value (fwd_value),
        .*
    );

    rv_hazard_control u_hazard (.*);

    rv_execute u_execute (.*);

    rv_memory u_memory (.*);

endmodule

`default_nettype wire

// ==== sim/tb_rv_model.svh ====
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

localparam int PROG_WORDS = 128;
localparam int DMEM_WORDS = 512;

word_t prog [PROG_WORDS];
word_t model_regs [`RV_NREGS];
word_t model_mem [DMEM_WORDS];
addr_t exp_addr [$];
word_t exp_data [$];
word_t model_pc;

// byte 0 travels in bits 31:24
function automatic word_t rev_word(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

function automatic word_t mem_pattern(input int idx);
    return (word_t'(idx) * 32'h9E37_79B9) ^ 32'h5A5A_0000;
endfunction

function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd,
                                input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2, input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// architectural run until the jal-to-self
task automatic model_run();
    word_t    pc_now, next_pc, ins, a, b, imm_i, ea, res;
    reg_idx_t rd;
    logic     wr;
    for (int r = 0; r < `RV_NREGS; r++) begin
        model_regs[r] = '0;
    end
    exp_addr.delete();
    exp_data.delete();
    pc_now = `RV_RESET_PC;
    for (int steps = 0; steps < 1000; steps++) begin
        ins     = prog[pc_now[8:2]];
        rd      = ins[11:7];
        a       = model_regs[ins[19:15]];
        b       = model_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        next_pc = pc_now + 32'd4;
        res     = '0;
        wr      = 1'b1;
        case (opcode_t'(ins[6:0]))
            opc_op:     res = alu_model(ins[14:12], ins[30], a, b);
            opc_op_imm: res = alu_model(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, imm_i);
            opc_load: begin
                ea  = a + imm_i;
                res = model_mem[ea[10:2]];
            end
            opc_store: begin
                ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                model_mem[ea[10:2]] = b;
                exp_addr.push_back(ea[31:2]);
                exp_data.push_back(rev_word(b));
                wr = 1'b0;
            end
            opc_branch: begin
                wr = 1'b0;
                if ((a == b) != ins[12]) begin
                    next_pc = pc_now + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                end
            end
            opc_jal: begin
                res     = pc_now + 32'd4;
                next_pc = pc_now + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
            end
            opc_jalr: begin
                res     = pc_now + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != '0) begin
            model_regs[rd] = res;
        end
        if (next_pc == pc_now) begin
            break;
        end
        pc_now = next_pc;
    end
    model_pc = pc_now;
endtask

`endif

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module tb_rv_core;
    import rv_pkg::*;

    `include "tb_rv_model.svh"

    localparam int NUM_TESTS   = 4;
    localparam int BODY_LEN    = 40;
    localparam int PROG_LEN    = BODY_LEN + 32;
    localparam int CYCLE_LIMIT = NUM_TESTS * 2 * PROG_LEN * 8;
    localparam int DATA_BASE   = 'h400;
    localparam int DUMP_BASE   = 'h200;

    logic  clk = 1'b0;
    logic  reset_r = 1'b1;
    logic  icache_stall = 1'b0;
    logic  dcache_stall = 1'b0;
    logic  icache_ren, dcache_ren, dcache_wen;
    addr_t icache_addr, dcache_addr;
    word_t icache_rdata, dcache_rdata, dcache_wdata, pc;

    word_t imem [PROG_WORDS];
    word_t dmem [DMEM_WORDS];
    int    seed;
    int    cycles = 0;
    int    errors, runs, failed_runs, store_count;
    logic  stall_on = 1'b0;

    // both memories answer in the same cycle
    // read data only while the core asks for it
    assign icache_rdata = icache_ren ? imem[icache_addr[6:0]] : '1;
    assign dcache_rdata = dcache_ren ? dmem[dcache_addr[8:0]] : '1;

    rv_core dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        #1;
        icache_stall = stall_on && (rand_below(4) == 0);
        dcache_stall = stall_on && (rand_below(4) == 0);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the core did not reach the end of its program in %0d cycles",
                     cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic check_store(input addr_t addr, input word_t data);
        if (store_count >= exp_addr.size()) begin
            $display("store %0d at %0t goes beyond the stores of the program", store_count,
                     $time);
            errors++;
        end else if (addr !== exp_addr[store_count] || data !== exp_data[store_count]) begin
            $display("mismatch at %0t: store %0d expected [%h] %h, got [%h] %h", $time,
                     store_count, exp_addr[store_count], exp_data[store_count], addr, data);
            errors++;
        end
        store_count++;
    endtask

    task automatic check_pc(input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("mismatch at %0t: pc expected %h, got %h", $time, expected, got);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, got);
            errors++;
        end
    endtask

    // random body, then dump x1..x31 and park on a self-loop
    task automatic gen_program();
        int         kind, k;
        reg_idx_t   rd, rs1, rs2;
        logic [2:0] f3;
        logic [11:0] imm;
        for (int i = 0; i < BODY_LEN; i++) begin
            kind = rand_below(10);
            rd   = reg_idx_t'(1 + rand_below(7));
            rs1  = reg_idx_t'(rand_below(8));
            rs2  = reg_idx_t'(rand_below(8));
            f3   = 3'(rand_below(7));
            if (f3 >= 3'd3) begin
                f3 = f3 + 3'd1;
            end
            k = 1 + rand_below(3);
            if (i + k > BODY_LEN) begin
                k = BODY_LEN - i;
            end
            imm = 12'(rand_below(4096));
            if (kind < 3) begin
                prog[i] = enc_r((f3 == 3'b000 || f3 == 3'b101) && rand_below(2) == 1
                                ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
            end else if (kind < 5) begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm[11:5] = (f3 == 3'b101 && rand_below(2) == 1) ? 7'h20 : 7'h00;
                end
                prog[i] = enc_i(imm, rs1, f3, rd, opc_op_imm);
            end else if (kind == 5) begin
                prog[i] = enc_i(12'(DATA_BASE + 4 * rand_below(16)), '0, 3'b010, rd, opc_load);
            end else if (kind == 6) begin
                prog[i] = enc_s(12'(DATA_BASE + 4 * rand_below(16)), rs2, '0);
            end else if (kind == 7) begin
                prog[i] = enc_b(13'(4 * k), rs2, rs1, rand_below(2) == 1 ? 3'b001 : 3'b000);
            end else if (kind == 8) begin
                prog[i] = enc_j(21'(4 * k), rd);
            end else begin
                prog[i] = enc_i(12'(4 * (i + k)), '0, 3'b000, rd, opc_jalr);
            end
        end
        for (int r = 1; r < `RV_NREGS; r++) begin
            prog[BODY_LEN + r - 1] = enc_s(12'(DUMP_BASE + 4 * r), reg_idx_t'(r), '0);
        end
        prog[PROG_LEN - 1] = enc_j('0, '0);
    endtask

    task automatic load_memories();
        for (int i = 0; i < PROG_WORDS; i++) begin
            // spare words are addi x0, x0, low address bits
            imem[i] = rev_word(i < PROG_LEN ? prog[i] : {12'(i), 20'h00013});
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = rev_word(mem_pattern(i));
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset_r = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset_r = 1'b0;
        @(negedge clk);
        check_flag("icache_ren", icache_ren, 1'b0);
        check_flag("dcache_ren", dcache_ren, 1'b0);
        check_flag("dcache_wen", dcache_wen, 1'b0);
        check_pc(pc, `RV_RESET_PC);
    endtask

    // a store lands only on a cycle where the pipeline moves
    task automatic observe_bus();
        if (dcache_wen && !dcache_stall && !icache_stall) begin
            check_store(dcache_addr, dcache_wdata);
            dmem[dcache_addr[8:0]] = dcache_wdata;
        end
    endtask

    task automatic run_program(input int t, input logic with_stalls);
        int    errors_before;
        word_t last_pc;
        errors_before = errors;
        load_memories();
        store_count = 0;
        apply_reset();
        stall_on = with_stalls;
        while (store_count < exp_addr.size()) begin
            @(negedge clk);
            observe_bus();
        end
        // forward-only code, so the first backward step is the self-loop
        last_pc = pc;
        @(negedge clk);
        observe_bus();
        while (pc >= last_pc) begin
            last_pc = pc;
            @(negedge clk);
            observe_bus();
        end
        stall_on = 1'b0;
        check_pc(pc, model_pc);
        runs++;
        if (errors != errors_before) begin
            failed_runs++;
        end
        $display("test %0d %s: %0d stores, loop at %h, %0d errors", t,
                 with_stalls ? "with stalls" : "without stalls", store_count, pc,
                 errors - errors_before);
    endtask

    initial begin
        seed        = 32'h7318;
        errors      = 0;
        runs        = 0;
        failed_runs = 0;
        store_count = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            gen_program();
            for (int i = 0; i < DMEM_WORDS; i++) begin
                model_mem[i] = mem_pattern(i);
            end
            model_run();
            run_program(t, 1'b0);
            run_program(t, 1'b1);
        end
        $display("%0d tests run, %0d failed, %0d errors", runs, failed_runs, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
+incdir+sim
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_hazard_control.sv
design/rv_execute.sv
design/rv_memory.sv
design/rv_core.sv
sim/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the RV32I pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f flist.f --top-module tb_rv_core -Mdir obj_dir -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
